/* design/zynq_shell_pkg.sv */
package zynq_shell_pkg;

   ////////////////////
   // widths
   ////////////////////

   // processor side addresses are one full word
   localparam int axil_addr_width_c  = 32;
   // the host port loses the top two address bits
   localparam int host_addr_width_c  = 30;
   localparam int csr_data_width_c   = 32;
   // one bit per 8 MiB region of processor DRAM space
   localparam int region_idx_width_c = 7;

   typedef logic [axil_addr_width_c-1:0]  axil_addr_t;
   typedef logic [host_addr_width_c-1:0]  host_addr_t;
   typedef logic [csr_data_width_c-1:0]   csr_word_t;
   typedef logic [region_idx_width_c-1:0] region_idx_t;

   // processor DRAM starts here, stripped before rebasing
   localparam axil_addr_t dram_xor_base_c = 32'h8000_0000;

   // profiler bitmap words visible to the host
   localparam int prof_words_c = 4;

   ////////////////////
   // enums
   ////////////////////

   typedef enum logic [2:0] {
      e_csr_sys_reset = 3'd0,
      e_csr_bitbang   = 3'd1,
      e_csr_dram_init = 3'd2,
      e_csr_dram_base = 3'd3,
      e_csr_prof0     = 3'd4,
      e_csr_prof1     = 3'd5,
      e_csr_prof2     = 3'd6,
      e_csr_prof3     = 3'd7
   } csr_idx_e;

   typedef enum logic [1:0] {
      e_win_dram    = 2'd0,
      e_win_local   = 2'd1,
      e_win_invalid = 2'd2
   } host_win_e;

   ////////////////////
   // structs
   ////////////////////

   // one DRAM request strobe from the processor
   typedef struct packed {
      logic       valid;
      axil_addr_t addr;
   } dram_req_s;

   // per channel result handed to the profiler
   typedef struct packed {
      logic        valid;
      region_idx_t region;
      logic        oor;
   } dram_hit_s;

endpackage

/* design/csr_bank.sv */
`timescale 1ns/1ns

module csr_bank (
   input  logic                                                  aclk,
   input  logic                                                  rst_n_i,
   input  logic                                                  csr_we_i,
   input  logic                                                  csr_re_i,
   input  zynq_shell_pkg::csr_idx_e                              csr_idx_i,
   input  zynq_shell_pkg::csr_word_t                             csr_wdata_i,
   input  zynq_shell_pkg::csr_word_t [zynq_shell_pkg::prof_words_c-1:0] prof_bits_i,
   output zynq_shell_pkg::csr_word_t                             csr_rdata_o,
   output logic                                                  csr_rvalid_o,
   output logic                                                  sys_resetn_o,
   output logic                                                  bb_data_o,
   output logic                                                  bb_v_o,
   output logic                                                  dram_init_o,
   output zynq_shell_pkg::axil_addr_t                            dram_base_o
);

   import zynq_shell_pkg::*;

   // host writable words, kept whole so they read back as written
   csr_word_t sys_reset_r;
   csr_word_t bitbang_r;
   csr_word_t dram_init_r;
   csr_word_t dram_base_r;

   logic      bb_v_r;
   logic      rvalid_r;
   csr_word_t rdata_r;
   csr_word_t rdata_mux;

   ////////////////////
   // write side
   ////////////////////

   always_ff @(posedge aclk) begin
      if (!rst_n_i) begin
         sys_reset_r <= '0;
         bitbang_r   <= '0;
         dram_init_r <= '0;
         dram_base_r <= '0;
      end else if (csr_we_i) begin
         case (csr_idx_i)
            e_csr_sys_reset: sys_reset_r <= csr_wdata_i;
            e_csr_bitbang:   bitbang_r   <= csr_wdata_i;
            e_csr_dram_init: dram_init_r <= csr_wdata_i;
            e_csr_dram_base: dram_base_r <= csr_wdata_i;
            // profiler words are read only
            default: ;
         endcase
      end
   end

   // one strobe per bit-bang write, lands with the new data bit
   always_ff @(posedge aclk) begin
      if (!rst_n_i) begin
         bb_v_r   <= 1'b0;
         rvalid_r <= 1'b0;
      end else begin
         bb_v_r   <= csr_we_i && (csr_idx_i == e_csr_bitbang);
         rvalid_r <= csr_re_i;
      end
   end

   ////////////////////
   // read side
   ////////////////////

   always_comb begin
      case (csr_idx_i)
         e_csr_sys_reset: rdata_mux = sys_reset_r;
         e_csr_bitbang:   rdata_mux = bitbang_r;
         e_csr_dram_init: rdata_mux = dram_init_r;
         e_csr_dram_base: rdata_mux = dram_base_r;
         // indices 4..7 select a profiler word
         default:         rdata_mux = prof_bits_i[csr_idx_i[1:0]];
      endcase
   end

   always_ff @(posedge aclk) begin
      if (csr_re_i) begin
         rdata_r <= rdata_mux;
      end
   end

   assign csr_rdata_o  = rdata_r;
   assign csr_rvalid_o = rvalid_r;
   // active low system reset, released by writing a 1
   assign sys_resetn_o = sys_reset_r[0];
   assign bb_data_o    = bitbang_r[0];
   assign bb_v_o       = bb_v_r;
   assign dram_init_o  = dram_init_r[0];
   assign dram_base_o  = dram_base_r;

endmodule

/* design/host_addr_xlate.sv */
`timescale 1ns/1ns

module host_addr_xlate (
   input  zynq_shell_pkg::host_addr_t hs_awaddr_i,
   input  zynq_shell_pkg::host_addr_t hs_araddr_i,
   output zynq_shell_pkg::axil_addr_t bp_awaddr_o,
   output zynq_shell_pkg::axil_addr_t bp_araddr_o,
   output zynq_shell_pkg::host_win_e  aw_win_o,
   output zynq_shell_pkg::host_win_e  ar_win_o
);

   import zynq_shell_pkg::*;

   ////////////////////
   // address map
   ////////////////////

   // host 0x0xxx_xxxx lands in processor DRAM at 0x8xxx_xxxx
   // host 0x2xxx_xxxx lands in processor local space at 0x0xxx_xxxx
   function automatic axil_addr_t xlate(input host_addr_t addr);
      return {~addr[29], 3'b000, addr[27:0]};
   endfunction

   // bit 28 has no home in either window
   function automatic host_win_e classify(input host_addr_t addr);
      host_win_e win;
      if (addr[28]) begin
         win = e_win_invalid;
      end else if (addr[29]) begin
         win = e_win_local;
      end else begin
         win = e_win_dram;
      end
      return win;
   endfunction

   // write and read address channels are handled the same way
   assign bp_awaddr_o = xlate(hs_awaddr_i);
   assign bp_araddr_o = xlate(hs_araddr_i);
   assign aw_win_o    = classify(hs_awaddr_i);
   assign ar_win_o    = classify(hs_araddr_i);

endmodule

/* design/dram_port_map.sv */
`timescale 1ns/1ns

module dram_port_map #(
   parameter zynq_shell_pkg::axil_addr_t mem_limit_p    = 32'h1000_0000,
   parameter int                         prof_regions_p = 128,
   parameter int                         region_lsb_p   = 23
) (
   input  zynq_shell_pkg::dram_req_s  req_i,
   input  zynq_shell_pkg::axil_addr_t dram_base_i,
   output zynq_shell_pkg::axil_addr_t addr_o,
   output zynq_shell_pkg::dram_hit_s  hit_o
);

   import zynq_shell_pkg::*;

   // index width follows the number of profiled regions
   localparam int region_w_lp = $clog2(prof_regions_p);

   axil_addr_t dram_offset;
   region_idx_t region_idx;

   ////////////////////
   // rebasing
   ////////////////////

   // strip the processor DRAM base, then move into the host allocation
   assign dram_offset = req_i.addr ^ dram_xor_base_c;
   assign addr_o      = dram_offset + dram_base_i;

   // region comes from the processor view of the address
   assign region_idx = region_idx_t'(req_i.addr[region_lsb_p +: region_w_lp]);

   always_comb begin
      hit_o.valid  = req_i.valid;
      hit_o.region = region_idx;
      // anything past the allocation is flagged but still passed on
      hit_o.oor    = (dram_offset >= mem_limit_p);
   end

endmodule

/* design/mem_profiler.sv */
`timescale 1ns/1ns

module mem_profiler #(
   parameter int prof_regions_p = 128
) (
   input  logic                                                  aclk,
   input  logic                                                  rst_n_i,
   input  logic                                                  sys_resetn_i,
   input  zynq_shell_pkg::dram_hit_s                             wr_hit_i,
   input  zynq_shell_pkg::dram_hit_s                             rd_hit_i,
   output zynq_shell_pkg::csr_word_t [zynq_shell_pkg::prof_words_c-1:0] prof_bits_o,
   output logic                                                  dram_oor_o
);

   import zynq_shell_pkg::*;

   localparam int prof_bits_lp = prof_words_c * $bits(csr_word_t);

   logic [prof_regions_p-1:0] map_r;
   logic [prof_regions_p-1:0] wr_set;
   logic [prof_regions_p-1:0] rd_set;
   logic [prof_bits_lp-1:0]   map_ext;
   logic                      oor_r;
   logic                      prof_clear;

   // one hot region bit per channel, empty when the channel is idle
   always_comb begin
      wr_set = '0;
      rd_set = '0;
      wr_set[wr_hit_i.region] = wr_hit_i.valid;
      rd_set[rd_hit_i.region] = rd_hit_i.valid;
   end

   // system reset wipes the history along with the core
   assign prof_clear = !rst_n_i || !sys_resetn_i;

   ////////////////////
   // sticky state
   ////////////////////

   always_ff @(posedge aclk) begin
      if (prof_clear) begin
         map_r <= '0;
         oor_r <= 1'b0;
      end else begin
         map_r <= map_r | wr_set | rd_set;
         oor_r <= oor_r
                  | (wr_hit_i.valid & wr_hit_i.oor)
                  | (rd_hit_i.valid & rd_hit_i.oor);
      end
   end

   // word 0 holds regions 31..0
   assign map_ext     = prof_bits_lp'(map_r);
   assign prof_bits_o = map_ext;
   assign dram_oor_o  = oor_r;

endmodule

/* design/zynq_shell_top.sv */
`timescale 1ns/1ns

module zynq_shell_top #(
   parameter zynq_shell_pkg::axil_addr_t mem_limit_p    = 32'h1000_0000,
   parameter int                         prof_regions_p = 128,
   parameter int                         region_lsb_p   = 23
) (
   input  logic                       aclk,
   input  logic                       rst_n_i,
   // host CSR strobes
   input  logic                       csr_we_i,
   input  logic                       csr_re_i,
   input  zynq_shell_pkg::csr_idx_e   csr_idx_i,
   input  zynq_shell_pkg::csr_word_t  csr_wdata_i,
   output zynq_shell_pkg::csr_word_t  csr_rdata_o,
   output logic                       csr_rvalid_o,
   output logic                       sys_resetn_o,
   output logic                       bb_data_o,
   output logic                       bb_v_o,
   output logic                       dram_init_o,
   // host window port
   input  zynq_shell_pkg::host_addr_t hs_awaddr_i,
   input  zynq_shell_pkg::host_addr_t hs_araddr_i,
   output zynq_shell_pkg::axil_addr_t hs_awaddr_o,
   output zynq_shell_pkg::axil_addr_t hs_araddr_o,
   output zynq_shell_pkg::host_win_e  hs_aw_win_o,
   output zynq_shell_pkg::host_win_e  hs_ar_win_o,
   // processor DRAM requests
   input  zynq_shell_pkg::dram_req_s  dram_wr_i,
   input  zynq_shell_pkg::dram_req_s  dram_rd_i,
   output zynq_shell_pkg::axil_addr_t dram_wr_addr_o,
   output zynq_shell_pkg::axil_addr_t dram_rd_addr_o,
   output logic                       dram_oor_o
);

   import zynq_shell_pkg::*;

   axil_addr_t dram_base;
   dram_hit_s  wr_hit;
   dram_hit_s  rd_hit;
   csr_word_t [prof_words_c-1:0] prof_bits;

   ////////////////////
   // host side
   ////////////////////

   csr_bank u_csr_bank (
      .aclk         (aclk),
      .rst_n_i      (rst_n_i),
      .csr_we_i     (csr_we_i),
      .csr_re_i     (csr_re_i),
      .csr_idx_i    (csr_idx_i),
      .csr_wdata_i  (csr_wdata_i),
      .prof_bits_i  (prof_bits),
      .csr_rdata_o  (csr_rdata_o),
      .csr_rvalid_o (csr_rvalid_o),
      .sys_resetn_o (sys_resetn_o),
      .bb_data_o    (bb_data_o),
      .bb_v_o       (bb_v_o),
      .dram_init_o  (dram_init_o),
      .dram_base_o  (dram_base)
   );

   host_addr_xlate u_xlate (
      .hs_awaddr_i (hs_awaddr_i),
      .hs_araddr_i (hs_araddr_i),
      .bp_awaddr_o (hs_awaddr_o),
      .bp_araddr_o (hs_araddr_o),
      .aw_win_o    (hs_aw_win_o),
      .ar_win_o    (hs_ar_win_o)
   );

   ////////////////////
   // DRAM side
   ////////////////////

   dram_port_map #(
      .mem_limit_p    (mem_limit_p),
      .prof_regions_p (prof_regions_p),
      .region_lsb_p   (region_lsb_p)
   ) u_wr_map (
      .req_i       (dram_wr_i),
      .dram_base_i (dram_base),
      .addr_o      (dram_wr_addr_o),
      .hit_o       (wr_hit)
   );

   dram_port_map #(
      .mem_limit_p    (mem_limit_p),
      .prof_regions_p (prof_regions_p),
      .region_lsb_p   (region_lsb_p)
   ) u_rd_map (
      .req_i       (dram_rd_i),
      .dram_base_i (dram_base),
      .addr_o      (dram_rd_addr_o),
      .hit_o       (rd_hit)
   );

   // held clear while the core sits in system reset
   mem_profiler #(
      .prof_regions_p (prof_regions_p)
   ) u_profiler (
      .aclk         (aclk),
      .rst_n_i      (rst_n_i),
      .sys_resetn_i (sys_resetn_o),
      .wr_hit_i     (wr_hit),
      .rd_hit_i     (rd_hit),
      .prof_bits_o  (prof_bits),
      .dram_oor_o   (dram_oor_o)
   );

endmodule

/* verif/zynq_shell_sva.sv */
`timescale 1ns/1ns

module zynq_shell_sva #(
   // 1 when attached to the CSR bank, 0 when attached to the profiler
   parameter bit bank_side_p = 1'b1
) (
   input logic aclk,
   input logic rst_n_i,
   input logic sys_resetn_i,
   input logic csr_re_i,
   input logic csr_rvalid_o,
   input logic bb_v_o,
   input logic dram_oor_o
);

   if (bank_side_p) begin : g_bank

      // bit-bang strobe lasts a single cycle
      bb_single_a : assert property (@(posedge aclk) disable iff (!rst_n_i)
         bb_v_o |=> !bb_v_o)
         else $error("bb_v_o stayed high for two cycles");

      // read data valid one cycle after the strobe
      rvalid_lag_a : assert property (@(posedge aclk) disable iff (!rst_n_i)
         csr_rvalid_o == $past(csr_re_i))
         else $error("csr_rvalid_o does not follow csr_re_i by one cycle");

   end else begin : g_prof

      // out of range flag only drops through system reset
      oor_sticky_a : assert property (@(posedge aclk) disable iff (!rst_n_i)
         $fell(dram_oor_o) |-> !$past(sys_resetn_i))
         else $error("dram_oor_o fell outside of system reset");

   end

endmodule

bind csr_bank zynq_shell_sva #(
   .bank_side_p (1'b1)
) u_bank_sva (
   .aclk         (aclk),
   .rst_n_i      (rst_n_i),
   .sys_resetn_i (sys_resetn_o),
   .csr_re_i     (csr_re_i),
   .csr_rvalid_o (csr_rvalid_o),
   .bb_v_o       (bb_v_o),
   .dram_oor_o   (1'b0)
);

bind mem_profiler zynq_shell_sva #(
   .bank_side_p (1'b0)
) u_prof_sva (
   .aclk         (aclk),
   .rst_n_i      (rst_n_i),
   .sys_resetn_i (sys_resetn_i),
   .csr_re_i     (1'b0),
   .csr_rvalid_o (1'b0),
   .bb_v_o       (1'b0),
   .dram_oor_o   (dram_oor_o)
);

/* verif/tb_zynq_shell.sv */
`timescale 1ns/1ns

module tb_zynq_shell;

   import zynq_shell_pkg::*;

   localparam int clk_half_c   = 4;
   localparam int wait_limit_c = 16;

   logic       aclk;
   logic       rst_n;
   logic       csr_we;
   logic       csr_re;
   csr_idx_e   csr_idx;
   csr_word_t  csr_wdata;
   csr_word_t  csr_rdata;
   logic       csr_rvalid;
   logic       sys_resetn;
   logic       bb_data;
   logic       bb_v;
   logic       dram_init;
   host_addr_t hs_awaddr;
   host_addr_t hs_araddr;
   axil_addr_t hs_awaddr_x;
   axil_addr_t hs_araddr_x;
   host_win_e  hs_aw_win;
   host_win_e  hs_ar_win;
   dram_req_s  dram_wr;
   dram_req_s  dram_rd;
   axil_addr_t dram_wr_addr;
   axil_addr_t dram_rd_addr;
   logic       dram_oor;

   // base last written to the DRAM base register
   axil_addr_t model_base;
   int         err_count;
   int         pass_count;
   int         fail_count;
   int         test_no;

   zynq_shell_top dut0 (
      .aclk           (aclk),
      .rst_n_i        (rst_n),
      .csr_we_i       (csr_we),
      .csr_re_i       (csr_re),
      .csr_idx_i      (csr_idx),
      .csr_wdata_i    (csr_wdata),
      .csr_rdata_o    (csr_rdata),
      .csr_rvalid_o   (csr_rvalid),
      .sys_resetn_o   (sys_resetn),
      .bb_data_o      (bb_data),
      .bb_v_o         (bb_v),
      .dram_init_o    (dram_init),
      .hs_awaddr_i    (hs_awaddr),
      .hs_araddr_i    (hs_araddr),
      .hs_awaddr_o    (hs_awaddr_x),
      .hs_araddr_o    (hs_araddr_x),
      .hs_aw_win_o    (hs_aw_win),
      .hs_ar_win_o    (hs_ar_win),
      .dram_wr_i      (dram_wr),
      .dram_rd_i      (dram_rd),
      .dram_wr_addr_o (dram_wr_addr),
      .dram_rd_addr_o (dram_rd_addr),
      .dram_oor_o     (dram_oor)
   );

   always #clk_half_c aclk = ~aclk;

   ////////////////////
   // compare tasks
   ////////////////////

   task automatic check_word(input csr_word_t got, input csr_word_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_addr(input axil_addr_t got, input axil_addr_t exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_win(input host_win_e got, input host_win_e exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s got %b, expected %b", $time, what, got, exp);
         err_count++;
      end
   endtask

   ////////////////////
   // drivers
   ////////////////////

   // called right after a rising edge; idle request addresses carry noise
   task automatic drive_idle();
      csr_we        <= 1'b0;
      csr_re        <= 1'b0;
      dram_wr.valid <= 1'b0;
      dram_wr.addr  <= $urandom;
      dram_rd.valid <= 1'b0;
      dram_rd.addr  <= $urandom;
   endtask

   // processor DRAM window moved into the host allocation
   function automatic axil_addr_t rebased(input axil_addr_t addr);
      return (addr ^ 32'h8000_0000) + model_base;
   endfunction

   task automatic write_csr(input csr_idx_e idx, input csr_word_t data, input logic exp);
      int   n;
      logic seen;
      @(posedge aclk);
      csr_we    <= 1'b1;
      csr_idx   <= idx;
      csr_wdata <= data;
      @(posedge aclk);
      drive_idle();
      if (idx == e_csr_dram_base) begin
         model_base = data;
      end
      if (idx == e_csr_bitbang) begin
         seen = 1'b0;
         n    = 0;
         while (!seen && n < wait_limit_c) begin
            @(negedge aclk);
            seen = bb_v;
            n++;
         end
         if (!seen) begin
            $display("timeout: no bit-bang strobe after a write at %0t ns", $time);
            err_count++;
         end else begin
            // strobe belongs in the cycle right after the write
            if (n != 1) begin
               $display("bit-bang strobe came %0d cycles after the write at %0t ns", n, $time);
               err_count++;
            end
            check_bit(bb_data, exp, "bb_data_o");
            // strobe must be gone one cycle later
            @(negedge aclk);
            check_bit(bb_v, 1'b0, "bb_v_o second cycle");
         end
      end else begin
         @(negedge aclk);
         if (idx == e_csr_sys_reset) begin
            check_bit(sys_resetn, exp, "sys_resetn_o");
         end else if (idx == e_csr_dram_init) begin
            check_bit(dram_init, exp, "dram_init_o");
         end
      end
   endtask

   task automatic read_csr(input csr_idx_e idx, input csr_word_t exp);
      int   n;
      logic seen;
      @(posedge aclk);
      csr_re  <= 1'b1;
      csr_idx <= idx;
      @(posedge aclk);
      drive_idle();
      seen = 1'b0;
      n    = 0;
      while (!seen && n < wait_limit_c) begin
         @(negedge aclk);
         seen = csr_rvalid;
         n++;
      end
      if (!seen) begin
         $display("timeout: csr_rvalid_o never rose after a read of index %0d", idx);
         err_count++;
      end else begin
         check_word(csr_rdata, exp, "csr_rdata_o");
      end
   endtask

   // each channel is checked while the other sits at host 0, which maps to 0x8000_0000
   task automatic translate_host(input host_addr_t haddr, input host_win_e win,
                                 input axil_addr_t exp);
      @(posedge aclk);
      hs_awaddr <= haddr;
      hs_araddr <= '0;
      @(negedge aclk);
      check_addr(hs_awaddr_x, exp, "hs_awaddr_o");
      check_win(hs_aw_win, win, "hs_aw_win_o");
      check_addr(hs_araddr_x, 32'h8000_0000, "hs_araddr_o at host 0");
      check_win(hs_ar_win, e_win_dram, "hs_ar_win_o at host 0");
      @(posedge aclk);
      hs_awaddr <= '0;
      hs_araddr <= haddr;
      @(negedge aclk);
      check_addr(hs_araddr_x, exp, "hs_araddr_o");
      check_win(hs_ar_win, win, "hs_ar_win_o");
      check_addr(hs_awaddr_x, 32'h8000_0000, "hs_awaddr_o at host 0");
      check_win(hs_aw_win, e_win_dram, "hs_aw_win_o at host 0");
   endtask

   task automatic issue_dram(input axil_addr_t waddr, input axil_addr_t raddr,
                             input logic exp_oor);
      @(posedge aclk);
      dram_wr.valid <= 1'b1;
      dram_wr.addr  <= waddr;
      dram_rd.valid <= 1'b1;
      dram_rd.addr  <= raddr;
      @(negedge aclk);
      check_addr(dram_wr_addr, rebased(waddr), "dram_wr_addr_o");
      check_addr(dram_rd_addr, rebased(raddr), "dram_rd_addr_o");
      @(posedge aclk);
      drive_idle();
      @(negedge aclk);
      check_bit(dram_oor, exp_oor, "dram_oor_o");
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         $display("test %0d %s: pass", test_no, name);
         pass_count++;
      end else begin
         $display("test %0d %s: fail", test_no, name);
         fail_count++;
      end
      test_no++;
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin
      int          fd;
      int          n_fields;
      int          errs_before;
      string       line;
      byte         cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] e;
      void'($urandom(32'hdd6c));
      aclk       = 1'b0;
      rst_n      = 1'b0;
      csr_we     = 1'b0;
      csr_re     = 1'b0;
      csr_idx    = e_csr_sys_reset;
      csr_wdata  = '0;
      hs_awaddr  = '0;
      hs_araddr  = '0;
      dram_wr    = '0;
      dram_rd    = '0;
      model_base = '0;
      err_count  = 0;
      pass_count = 0;
      fail_count = 0;
      test_no    = 0;
      repeat (2) @(posedge aclk);
      rst_n <= 1'b1;
      @(negedge aclk);
      errs_before = err_count;
      check_bit(csr_rvalid, 1'b0, "csr_rvalid_o after reset");
      check_bit(bb_v, 1'b0, "bb_v_o after reset");
      check_bit(sys_resetn, 1'b0, "sys_resetn_o after reset");
      check_bit(dram_init, 1'b0, "dram_init_o after reset");
      check_bit(dram_oor, 1'b0, "dram_oor_o after reset");
      report_test("reset values", errs_before);
      fd = $fopen("verif/shell_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file verif/shell_input.txt");
         fail_count++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
               continue;
            end
            n_fields = $sscanf(line, "%c %h %h %h", cmd, a, b, e);
            if (n_fields != 4) begin
               $display("stimulus line could not be parsed: %s", line);
               fail_count++;
               continue;
            end
            errs_before = err_count;
            case (cmd)
               "W": write_csr(csr_idx_e'(a[2:0]), b, e[0]);
               "R": read_csr(csr_idx_e'(a[2:0]), e);
               "H": translate_host(host_addr_t'(a), host_win_e'(b[1:0]), e);
               "D": issue_dram(a, b, e[0]);
               default: begin
                  $display("unknown stimulus command %c", cmd);
                  err_count++;
               end
            endcase
            report_test($sformatf("%c %h %h", cmd, a, b), errs_before);
         end
         $fclose(fd);
      end
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* verif/shell_input.txt */
# columns: cmd a b e, all hex
# W idx wdata exp_bit | R idx 0 exp_word | H host_addr exp_win exp_addr | D wr rd exp_oor
R 0 0 00000000
R 3 0 00000000
R 4 0 00000000
W 0 00000001 1
R 0 0 00000001
W 2 a5a50003 1
R 2 0 a5a50003
W 3 10000000 0
R 3 0 10000000
W 1 00000001 1
W 1 00000002 0
R 1 0 00000002
H 00001000 0 80001000
H 20000040 1 00000040
H 1ffffffc 2 8ffffffc
H 30000000 2 00000000
H 2abcdef0 1 0abcdef0
D 80000000 80800000 0
R 4 0 00000003
D 82000000 8fc00000 0
R 4 0 80000013
D 90000000 80000000 1
D 80001000 80002000 1
D bf800000 a0000000 1
R 5 0 00000001
R 6 0 00000001
R 7 0 80000000
W 4 ffffffff 0
R 4 0 80000013
W 0 00000000 0
D 80000000 80000000 0
R 4 0 00000000
R 7 0 00000000

/* flist.f */
design/zynq_shell_pkg.sv
design/csr_bank.sv
design/host_addr_xlate.sv
design/dram_port_map.sv
design/mem_profiler.sv
design/zynq_shell_top.sv
verif/zynq_shell_sva.sv
verif/tb_zynq_shell.sv

/* Bender.yml */
package:
  name: zynq_shell

sources:
  - design/zynq_shell_pkg.sv
  - design/csr_bank.sv
  - design/host_addr_xlate.sv
  - design/dram_port_map.sv
  - design/mem_profiler.sv
  - design/zynq_shell_top.sv
  - target: test
    files:
      - verif/zynq_shell_sva.sv
      - verif/tb_zynq_shell.sv
